// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes
    localparam logic [6:0] OP     = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] LUI    = 7'b0110111;
    localparam logic [6:0] JAL    = 7'b1101111;
    localparam logic [6:0] JALR   = 7'b1100111;
    localparam logic [6:0] BRANCH = 7'b1100011;
    localparam logic [6:0] LOAD   = 7'b0000011;
    localparam logic [6:0] STORE  = 7'b0100011;

    // alu funct3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // access width, word when none of these
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // one instruction word, four views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
    } inst_u;

    typedef struct packed {
        logic [2:0] funct3;
        logic       alt;
    } alu_op_t;

    typedef struct packed {
        logic       alu;
        logic       mem;
        logic       branch;
        logic       jump;
        logic       jump_reg;
        logic       upper;
        logic       imm_op;
        logic       store;
        logic [2:0] funct3;
        logic       alt;
        reg_addr_t  rd;
        word_t      rs1_val;
        word_t      rs2_val;
        word_t      imm;
    } dec_t;

endpackage

// ==== source/regs.sv ====
`timescale 1ns/100ps

module regs import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      we,
    input  reg_addr_t rd,
    input  word_t     wd,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rd1,
    output word_t     rd2
);

    word_t rf [32];

    // x0 is cleared by reset and never written
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            rf[rd] <= wd;
        end
    end

    assign rd1 = rf[rs1];
    assign rd2 = rf[rs2];

endmodule

// ==== source/fetch.sv ====
`timescale 1ns/100ps

module fetch import cpu_pkg::*; #(
    parameter int INST_ADDR_W = 10
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   order,
    input  word_t                  pc,
    output logic                   done,
    output inst_u                  inst,
    output logic [INST_ADDR_W-1:0] a_inst,
    input  word_t                  d_inst
);

    logic wait_mem;

    // word address, the memory answers one cycle later
    assign a_inst = pc[INST_ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wait_mem <= 1'b0;
            done     <= 1'b0;
        end else begin
            wait_mem <= order;
            done     <= wait_mem;
        end
    end

    // held until the next order
    always_ff @(posedge clk) begin
        if (wait_mem) begin
            inst <= d_inst;
        end
    end

endmodule

// ==== source/decode.sv ====
`timescale 1ns/100ps

module decode import cpu_pkg::*; (
    input  inst_u     inst,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    input  word_t     rd1,
    input  word_t     rd2,
    output dec_t      dec
);

    logic [6:0] opcode;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = inst.r_fmt.opcode;
    assign rs1    = inst.r_fmt.rs1;
    assign rs2    = inst.r_fmt.rs2;

    assign imm_i = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
    assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};

    // b-type reuses the s-type fields with the bits shuffled
    assign imm_b = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_lo[0],
                    inst.s_fmt.imm_hi[5:0], inst.s_fmt.imm_lo[4:1], 1'b0};

    assign imm_u = {inst.u_fmt.imm20, 12'b0};

    // j-type likewise from the u-type field
    assign imm_j = {{12{inst.u_fmt.imm20[19]}}, inst.u_fmt.imm20[7:0],
                    inst.u_fmt.imm20[8], inst.u_fmt.imm20[18:9], 1'b0};

    always_comb begin
        dec         = '0;
        dec.funct3  = inst.r_fmt.funct3;
        dec.alt     = inst.r_fmt.funct7[5];
        dec.rd      = inst.r_fmt.rd;
        dec.rs1_val = rd1;
        dec.rs2_val = rd2;
        case (opcode)
            OP: begin
                dec.alu = 1'b1;
            end
            OP_IMM: begin
                dec.alu    = 1'b1;
                dec.imm_op = 1'b1;
                dec.imm    = imm_i;
            end
            LUI: begin
                dec.upper = 1'b1;
                dec.imm   = imm_u;
            end
            JAL: begin
                dec.jump = 1'b1;
                dec.imm  = imm_j;
            end
            JALR: begin
                dec.jump_reg = 1'b1;
                dec.imm      = imm_i;
            end
            BRANCH: begin
                dec.branch = 1'b1;
                dec.imm    = imm_b;
            end
            LOAD: begin
                dec.mem = 1'b1;
                dec.imm = imm_i;
            end
            STORE: begin
                dec.mem   = 1'b1;
                dec.store = 1'b1;
                dec.imm   = imm_s;
            end
            // unknown opcode leaves every class flag low
            default: begin
                dec.imm = '0;
            end
        endcase
    end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/100ps

module alu import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rstn,
    input  logic    order,
    input  alu_op_t op,
    input  logic    imm_op,
    input  word_t   a,
    input  word_t   b,
    output logic    done,
    output word_t   y
);

    logic [4:0] shamt;
    word_t      sra_res;
    word_t      res;

    assign shamt   = b[4:0];
    assign sra_res = $signed(a) >>> shamt;

    always_comb begin
        case (op.funct3)
            // addi has no sub form, so alt is ignored there
            F3_ADD:  res = (op.alt && !imm_op) ? a - b : a + b;
            F3_SLL:  res = a << shamt;
            F3_SLT:  res = {31'b0, $signed(a) < $signed(b)};
            F3_SLTU: res = {31'b0, a < b};
            F3_XOR:  res = a ^ b;
            F3_SRL:  res = op.alt ? sra_res : a >> shamt;
            F3_OR:   res = a | b;
            F3_AND:  res = a & b;
            default: res = a & b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            done <= 1'b0;
        end else begin
            done <= order;
        end
    end

    always_ff @(posedge clk) begin
        if (order) begin
            y <= res;
        end
    end

endmodule

// ==== source/mem_access.sv ====
`timescale 1ns/100ps

module mem_access import cpu_pkg::*; #(
    parameter int DATA_ADDR_W = 10
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   order,
    input  logic                   store,
    input  logic [2:0]             funct3,
    input  word_t                  base,
    input  word_t                  offset,
    input  word_t                  wdata,
    output logic                   done,
    output word_t                  rdata,
    output logic [DATA_ADDR_W-1:0] a_mem,
    output word_t                  sd_mem,
    input  word_t                  ld_mem,
    output logic [3:0]             mem_write_flag,
    output logic                   mem_read_flag
);

    word_t      addr;
    logic [3:0] strb;
    logic       ld_wait;
    logic [2:0] ld_f3;
    logic [1:0] ld_off;
    logic [7:0] ld_byte;
    logic [15:0] ld_half;
    word_t      ld_val;

    assign addr  = base + offset;
    assign a_mem = addr[DATA_ADDR_W+1:2];

    // requests go out in the order cycle itself
    assign mem_read_flag  = order & ~store;
    assign mem_write_flag = (order && store) ? strb : 4'b0000;

    always_comb begin
        case (funct3)
            F3_B: begin
                strb   = 4'b0001 << addr[1:0];
                sd_mem = {4{wdata[7:0]}};
            end
            F3_H: begin
                strb   = 4'b0011 << {addr[1], 1'b0};
                sd_mem = {2{wdata[15:0]}};
            end
            default: begin
                strb   = 4'b1111;
                sd_mem = wdata;
            end
        endcase
    end

    assign ld_byte = ld_mem[8*ld_off +: 8];
    assign ld_half = ld_off[1] ? ld_mem[31:16] : ld_mem[15:0];

    always_comb begin
        case (ld_f3)
            F3_B:    ld_val = {{24{ld_byte[7]}}, ld_byte};
            F3_BU:   ld_val = {24'b0, ld_byte};
            F3_H:    ld_val = {{16{ld_half[15]}}, ld_half};
            F3_HU:   ld_val = {16'b0, ld_half};
            default: ld_val = ld_mem;
        endcase
    end

    // stores finish after one cycle, loads after two
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ld_wait <= 1'b0;
            done    <= 1'b0;
        end else begin
            ld_wait <= order & ~store;
            done    <= (order & store) | ld_wait;
        end
    end

    always_ff @(posedge clk) begin
        if (order) begin
            ld_f3  <= funct3;
            ld_off <= addr[1:0];
        end
        if (ld_wait) begin
            rdata <= ld_val;
        end
    end

endmodule

// ==== source/cpu.sv ====
`timescale 1ns/100ps

module cpu import cpu_pkg::*; #(
    parameter int INST_ADDR_W = 10,
    parameter int DATA_ADDR_W = 10
) (
    input  logic                   clk,
    input  logic                   rstn,
    output logic [INST_ADDR_W-1:0] a_inst,
    input  word_t                  d_inst,
    output logic [DATA_ADDR_W-1:0] a_mem,
    output word_t                  sd_mem,
    input  word_t                  ld_mem,
    output logic [3:0]             mem_write_flag,
    output logic                   mem_read_flag,
    output logic                   halted
);

    localparam logic [2:0] S_FETCH        = 3'd0;
    localparam logic [2:0] S_FETCH_WAIT   = 3'd1;
    localparam logic [2:0] S_DECODE       = 3'd2;
    localparam logic [2:0] S_EXECUTE      = 3'd3;
    localparam logic [2:0] S_EXECUTE_WAIT = 3'd4;
    localparam logic [2:0] S_WRITE        = 3'd5;
    localparam logic [2:0] S_END          = 3'd6;

    logic [2:0] state;
    word_t      pc;
    word_t      next_pc;
    word_t      wb_val;

    logic       reg_we;
    word_t      reg_wd;
    reg_addr_t  rs1_a;
    reg_addr_t  rs2_a;
    word_t      rd1;
    word_t      rd2;

    logic       fetch_order;
    logic       fetch_done;
    inst_u      inst;
    dec_t       dec_d;
    dec_t       dec_r;

    logic       alu_order;
    logic       alu_done;
    alu_op_t    alu_op;
    word_t      alu_b;
    word_t      alu_y;

    logic       mem_order;
    logic       mem_done;
    word_t      mem_rdata;

    logic       take_branch;
    logic       unit_done;

    regs u_regs (
        .clk(clk), .rstn(rstn), .we(reg_we), .rd(dec_r.rd), .wd(reg_wd),
        .rs1(rs1_a), .rs2(rs2_a), .rd1(rd1), .rd2(rd2)
    );

    fetch #(.INST_ADDR_W(INST_ADDR_W)) u_fetch (
        .clk(clk), .rstn(rstn), .order(fetch_order), .pc(pc), .done(fetch_done),
        .inst(inst), .a_inst(a_inst), .d_inst(d_inst)
    );

    decode u_decode (
        .inst(inst), .rs1(rs1_a), .rs2(rs2_a), .rd1(rd1), .rd2(rd2), .dec(dec_d)
    );

    alu u_alu (
        .clk(clk), .rstn(rstn), .order(alu_order), .op(alu_op), .imm_op(dec_r.imm_op),
        .a(dec_r.rs1_val), .b(alu_b), .done(alu_done), .y(alu_y)
    );

    mem_access #(.DATA_ADDR_W(DATA_ADDR_W)) u_mem_access (
        .clk(clk), .rstn(rstn), .order(mem_order), .store(dec_r.store),
        .funct3(dec_r.funct3), .base(dec_r.rs1_val), .offset(dec_r.imm),
        .wdata(dec_r.rs2_val), .done(mem_done), .rdata(mem_rdata), .a_mem(a_mem),
        .sd_mem(sd_mem), .ld_mem(ld_mem), .mem_write_flag(mem_write_flag),
        .mem_read_flag(mem_read_flag)
    );

    assign alu_op = '{funct3: dec_r.funct3, alt: dec_r.alt};
    assign alu_b  = dec_r.imm_op ? dec_r.imm : dec_r.rs2_val;

    // branch comparator
    always_comb begin
        case (dec_r.funct3)
            F3_BEQ:  take_branch = dec_r.rs1_val == dec_r.rs2_val;
            F3_BNE:  take_branch = dec_r.rs1_val != dec_r.rs2_val;
            F3_BLT:  take_branch = $signed(dec_r.rs1_val) < $signed(dec_r.rs2_val);
            F3_BGE:  take_branch = $signed(dec_r.rs1_val) >= $signed(dec_r.rs2_val);
            F3_BLTU: take_branch = dec_r.rs1_val < dec_r.rs2_val;
            F3_BGEU: take_branch = dec_r.rs1_val >= dec_r.rs2_val;
            default: take_branch = 1'b0;
        endcase
    end

    assign unit_done = dec_r.mem ? mem_done : alu_done;

    // unit results are written in the cycle their done arrives
    always_comb begin
        reg_we = 1'b0;
        reg_wd = wb_val;
        if (state == S_WRITE) begin
            reg_we = dec_r.upper | dec_r.jump | dec_r.jump_reg;
        end else if (state == S_EXECUTE_WAIT) begin
            reg_we = unit_done & ~dec_r.store;
            reg_wd = dec_r.mem ? mem_rdata : alu_y;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            dec_r <= dec_d;
        end
        if (state == S_EXECUTE) begin
            next_pc <= pc + 32'd4;
            wb_val  <= pc + 32'd4;
            if ((dec_r.branch && take_branch) || dec_r.jump) begin
                next_pc <= pc + dec_r.imm;
            end
            if (dec_r.jump_reg) begin
                next_pc <= (dec_r.rs1_val + dec_r.imm) & ~32'd1;
            end
            if (dec_r.upper) begin
                wb_val <= dec_r.imm;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= S_FETCH;
            pc          <= '0;
            fetch_order <= 1'b0;
            alu_order   <= 1'b0;
            mem_order   <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    // order is normally raised on the way in, except after reset
                    fetch_order <= ~fetch_order;
                    if (fetch_order) begin
                        state <= S_FETCH_WAIT;
                    end
                end
                S_FETCH_WAIT: begin
                    if (fetch_done) begin
                        state <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    alu_order <= dec_d.alu;
                    mem_order <= dec_d.mem;
                    state     <= S_EXECUTE;
                end
                S_EXECUTE: begin
                    alu_order <= 1'b0;
                    mem_order <= 1'b0;
                    if (dec_r.alu || dec_r.mem) begin
                        state <= S_EXECUTE_WAIT;
                    end else if (dec_r.branch || dec_r.jump || dec_r.jump_reg ||
                                 dec_r.upper) begin
                        state <= S_WRITE;
                    end else begin
                        state <= S_END;
                    end
                end
                S_EXECUTE_WAIT: begin
                    if (unit_done) begin
                        pc          <= {next_pc[31:2], 2'b00};
                        fetch_order <= 1'b1;
                        state       <= S_FETCH;
                    end
                end
                S_WRITE: begin
                    pc          <= {next_pc[31:2], 2'b00};
                    fetch_order <= 1'b1;
                    state       <= S_FETCH;
                end
                // halted until the next reset
                default: begin
                    state <= S_END;
                end
            endcase
        end
    end

    assign halted = (state == S_END);

endmodule

// ==== bench/cpu_chk.sv ====
`timescale 1ns/100ps

module cpu_chk (
    input logic       clk,
    input logic       rstn,
    input logic [3:0] mem_write_flag,
    input logic       mem_read_flag,
    input logic       fetch_order,
    input logic       halted
);

    // a read and a write never share a cycle
    assert property (@(posedge clk) disable iff (!rstn)
        !((|mem_write_flag) && mem_read_flag))
    else $error("memory read and write requested in the same cycle");

    // store strobes are single cycle pulses
    assert property (@(posedge clk) disable iff (!rstn)
        (|mem_write_flag) |=> !(|mem_write_flag))
    else $error("write strobes held longer than one cycle");

    assert property (@(posedge clk) disable iff (!rstn)
        fetch_order |=> !fetch_order)
    else $error("fetch order held longer than one cycle");

    // only a reset clears halted
    assert property (@(posedge clk)
        (halted && rstn) |=> halted)
    else $error("halted fell without a reset");

endmodule

bind cpu cpu_chk u_chk (
    .clk(clk),
    .rstn(rstn),
    .mem_write_flag(mem_write_flag),
    .mem_read_flag(mem_read_flag),
    .fetch_order(fetch_order),
    .halted(halted)
);

// ==== bench/tb_cpu.sv ====
`timescale 1ns/100ps

module tb_cpu import cpu_pkg::*; ();

    localparam int PROGRAMS   = 31;
    localparam int MAX_INST   = 64;
    localparam int MAX_CYCLES = PROGRAMS * (16 + 2 + MAX_INST * 7) + 200;

    logic       clk = 1'b0;
    logic       rstn = 1'b0;
    logic       fill_req = 1'b0;
    logic [9:0] a_inst;
    word_t      d_inst = '0;
    logic [9:0] a_mem;
    word_t      sd_mem;
    word_t      ld_mem = '0;
    logic [3:0] mem_write_flag;
    logic       mem_read_flag;
    logic       halted;

    word_t imem [1024];
    word_t dmem [1024];
    word_t prog [$];
    int    seed = 53;
    int    cycles = 0;

    cpu #(.INST_ADDR_W(10), .DATA_ADDR_W(10)) uut (
        .clk(clk), .rstn(rstn), .a_inst(a_inst), .d_inst(d_inst), .a_mem(a_mem),
        .sd_mem(sd_mem), .ld_mem(ld_mem), .mem_write_flag(mem_write_flag),
        .mem_read_flag(mem_read_flag), .halted(halted)
    );

    always #10 clk = ~clk;

    // pattern over the whole word index
    function automatic word_t fill_value(input int i);
        return (32'(i) * 32'h9e3779b1) ^ 32'h5a5a0000;
    endfunction

    // both memories answer one cycle after the address
    always @(posedge clk) begin
        d_inst <= #1 imem[a_inst];
        // without a read request the data bus carries the inverted word
        if (mem_read_flag) begin
            ld_mem <= #1 dmem[a_mem];
        end else begin
            ld_mem <= #1 ~dmem[a_mem];
        end
        if (fill_req) begin
            for (int i = 0; i < 1024; i++) begin
                dmem[i] = fill_value(i);
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (mem_write_flag[b]) begin
                    dmem[a_mem][8*b +: 8] = sd_mem[8*b +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the core did not halt within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    task automatic stop_on_error();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    // instruction encoders
    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    // lui plus addi with the addi sign extension compensated in the upper part
    task automatic load_const(input reg_addr_t rd, input word_t v);
        word_t hi;
        hi = v + 32'h800;
        emit({hi[31:12], rd, LUI});
        emit(enc_i(v[11:0], rd, F3_ADD, rd, OP_IMM));
    endtask

    task automatic store_word(input reg_addr_t rs, input int byte_addr);
        emit(enc_s(12'(byte_addr), rs, 5'd0, 3'b010));
    endtask

    // load the program, reset the core and wait for halt
    task automatic run_program();
        @(posedge clk);
        #1;
        rstn     = 1'b0;
        fill_req = 1'b1;
        for (int i = 0; i < 1024; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
        end
        @(posedge clk);
        #1;
        fill_req = 1'b0;
        repeat (15) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(posedge clk);
        #1;
        while (!halted) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_word(input int idx, input word_t want, input string what);
        assert (dmem[idx] === want) else begin
            $display("ERR %s dmem[%0h] = %h, expected %h", what, idx, dmem[idx], want);
            stop_on_error();
        end
    endtask

    task automatic test_alu();
        word_t       a;
        word_t       b;
        word_t       r;
        word_t       iv;
        logic [11:0] imm;
        logic [4:0]  sh;
        word_t       want [19];
        for (int p = 0; p < 20; p++) begin
            a   = $random(seed);
            b   = $random(seed);
            r   = $random(seed);
            imm = r[11:0];
            iv  = {{20{imm[11]}}, imm};
            sh  = imm[4:0];
            prog.delete();
            load_const(5'd1, a);
            load_const(5'd2, b);
            emit(enc_r(7'h00, 5'd2, 5'd1, F3_ADD, 5'd3));
            store_word(5'd3, 0);
            emit(enc_r(7'h20, 5'd2, 5'd1, F3_ADD, 5'd3));
            store_word(5'd3, 4);
            emit(enc_r(7'h00, 5'd2, 5'd1, F3_SLL, 5'd3));
            store_word(5'd3, 8);
            emit(enc_r(7'h00, 5'd2, 5'd1, F3_SLT, 5'd3));
            store_word(5'd3, 12);
            emit(enc_r(7'h00, 5'd2, 5'd1, F3_SLTU, 5'd3));
            store_word(5'd3, 16);
            emit(enc_r(7'h00, 5'd2, 5'd1, F3_XOR, 5'd3));
            store_word(5'd3, 20);
            emit(enc_r(7'h00, 5'd2, 5'd1, F3_SRL, 5'd3));
            store_word(5'd3, 24);
            emit(enc_r(7'h20, 5'd2, 5'd1, F3_SRL, 5'd3));
            store_word(5'd3, 28);
            emit(enc_r(7'h00, 5'd2, 5'd1, F3_OR, 5'd3));
            store_word(5'd3, 32);
            emit(enc_r(7'h00, 5'd2, 5'd1, F3_AND, 5'd3));
            store_word(5'd3, 36);
            emit(enc_i(imm, 5'd1, F3_ADD, 5'd3, OP_IMM));
            store_word(5'd3, 40);
            emit(enc_i(imm, 5'd1, F3_SLT, 5'd3, OP_IMM));
            store_word(5'd3, 44);
            emit(enc_i(imm, 5'd1, F3_SLTU, 5'd3, OP_IMM));
            store_word(5'd3, 48);
            emit(enc_i(imm, 5'd1, F3_XOR, 5'd3, OP_IMM));
            store_word(5'd3, 52);
            emit(enc_i(imm, 5'd1, F3_OR, 5'd3, OP_IMM));
            store_word(5'd3, 56);
            emit(enc_i(imm, 5'd1, F3_AND, 5'd3, OP_IMM));
            store_word(5'd3, 60);
            emit(enc_i({7'h00, sh}, 5'd1, F3_SLL, 5'd3, OP_IMM));
            store_word(5'd3, 64);
            emit(enc_i({7'h00, sh}, 5'd1, F3_SRL, 5'd3, OP_IMM));
            store_word(5'd3, 68);
            emit(enc_i({7'h20, sh}, 5'd1, F3_SRL, 5'd3, OP_IMM));
            store_word(5'd3, 72);
            emit(32'h0);
            want[0]  = a + b;
            want[1]  = a - b;
            want[2]  = a << b[4:0];
            want[3]  = {31'b0, $signed(a) < $signed(b)};
            want[4]  = {31'b0, a < b};
            want[5]  = a ^ b;
            want[6]  = a >> b[4:0];
            want[7]  = $signed(a) >>> b[4:0];
            want[8]  = a | b;
            want[9]  = a & b;
            want[10] = a + iv;
            want[11] = {31'b0, $signed(a) < $signed(iv)};
            want[12] = {31'b0, a < iv};
            want[13] = a ^ iv;
            want[14] = a | iv;
            want[15] = a & iv;
            want[16] = a << sh;
            want[17] = a >> sh;
            want[18] = $signed(a) >>> sh;
            run_program();
            for (int k = 0; k < 19; k++) begin
                check_word(k, want[k], "alu result");
            end
        end
    endtask

    task automatic test_mem();
        word_t v;
        word_t r;
        word_t w0;
        word_t w1;
        v = $random(seed);
        r = $random(seed);
        prog.delete();
        load_const(5'd1, v);
        store_word(5'd1, 32'h100);
        emit(enc_i(12'h100, 5'd0, 3'b010, 5'd4, LOAD));
        store_word(5'd4, 32'h104);
        load_const(5'd2, {24'h0, r[7:0]});
        load_const(5'd3, {24'h0, r[15:8]});
        emit(enc_s(12'h200, 5'd2, 5'd0, F3_B));
        emit(enc_s(12'h202, 5'd3, 5'd0, F3_B));
        emit(enc_s(12'h211, 5'd2, 5'd0, F3_B));
        emit(enc_s(12'h213, 5'd3, 5'd0, F3_B));
        emit(enc_i(12'h200, 5'd0, 3'b010, 5'd4, LOAD));
        store_word(5'd4, 32'h300);
        emit(enc_i(12'h210, 5'd0, 3'b010, 5'd4, LOAD));
        store_word(5'd4, 32'h304);
        emit(32'h0);
        w0 = fill_value(32'h200 / 4);
        w0[7:0]   = r[7:0];
        w0[23:16] = r[15:8];
        w1 = fill_value(32'h210 / 4);
        w1[15:8]  = r[7:0];
        w1[31:24] = r[15:8];
        run_program();
        check_word(32'h100 / 4, v, "sw word");
        check_word(32'h104 / 4, v, "lw of sw");
        check_word(32'h200 / 4, w0, "sb lanes 0 2");
        check_word(32'h210 / 4, w1, "sb lanes 1 3");
        check_word(32'h300 / 4, w0, "lw merged lanes 0 2");
        check_word(32'h304 / 4, w1, "lw merged lanes 1 3");
    endtask

    task automatic test_branch();
        word_t      a;
        word_t      b;
        logic       taken;
        logic [2:0] f3s [6];
        f3s = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        for (int p = 0; p < 8; p++) begin
            a = $random(seed);
            b = (p == 0) ? a : $random(seed);
            prog.delete();
            load_const(5'd1, a);
            load_const(5'd2, b);
            load_const(5'd5, 32'h600d0000 + 32'(p));
            for (int j = 0; j < 6; j++) begin
                emit(enc_b(13'd8, 5'd2, 5'd1, f3s[j]));
                store_word(5'd5, 4 * j);
            end
            emit(32'h0);
            run_program();
            for (int j = 0; j < 6; j++) begin
                case (j)
                    0: taken = (a == b);
                    1: taken = (a != b);
                    2: taken = ($signed(a) < $signed(b));
                    3: taken = ($signed(a) >= $signed(b));
                    4: taken = (a < b);
                    default: taken = (a >= b);
                endcase
                check_word(j, taken ? fill_value(j) : 32'h600d0000 + 32'(p),
                           "branch marker");
            end
        end
    endtask

    task automatic test_jump();
        prog.delete();
        emit(enc_j(21'd8, 5'd1));
        emit(32'h0);
        store_word(5'd1, 32'h400);
        load_const(5'd6, 32'hcafe1234);
        store_word(5'd6, 32'h404);
        emit(enc_i(12'd40, 5'd0, F3_ADD, 5'd7, OP_IMM));
        // jalr at 28 lands on 44
        emit(enc_i(12'd4, 5'd7, 3'b000, 5'd8, JALR));
        emit(32'h0);
        emit(32'h0);
        emit(32'h0);
        store_word(5'd8, 32'h408);
        store_word(5'd6, 32'h40c);
        emit({20'hbeef5, 5'd9, LUI});
        store_word(5'd9, 32'h410);
        emit(32'h0);
        run_program();
        check_word(32'h400 / 4, 32'd4, "jal link");
        check_word(32'h404 / 4, 32'hcafe1234, "jal target marker");
        check_word(32'h408 / 4, 32'd32, "jalr link");
        check_word(32'h40c / 4, 32'hcafe1234, "jalr target marker");
        check_word(32'h410 / 4, 32'hbeef5000, "lui value");
    endtask

    task automatic test_halt();
        prog.delete();
        emit(enc_i(12'd123, 5'd0, F3_ADD, 5'd0, OP_IMM));
        store_word(5'd0, 32'h500);
        emit(enc_i(12'h055, 5'd0, F3_ADD, 5'd1, OP_IMM));
        emit(32'hffffffff);
        store_word(5'd1, 32'h504);
        emit(32'h0);
        run_program();
        repeat (20) @(posedge clk);
        #1;
        assert (halted === 1'b1) else begin
            $display("the core left the halted state without a reset");
            stop_on_error();
        end
        check_word(32'h500 / 4, 32'h0, "x0 store");
        check_word(32'h504 / 4, fill_value(32'h504 / 4), "store after halt");
    endtask

    initial begin
        test_alu();
        test_mem();
        test_branch();
        test_jump();
        test_halt();
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== tb.f ====
source/cpu_pkg.sv
source/regs.sv
source/fetch.sv
source/decode.sv
source/alu.sv
source/mem_access.sv
source/cpu.sv
bench/cpu_chk.sv
bench/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu -f tb.f \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation returned status $sim_status"
    exit 1
fi
exit 0
